/* project.f */
+incdir+source
source/membus_pkg.sv
source/arena_decoder.sv
source/mem_bank.sv
source/led_port.sv
source/bus_reply.sv
source/membus_top.sv
sim/membus_checker.sv
sim/membus_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= membus_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Simulation passed

SOURCES := $(wildcard source/*.sv source/*.svh sim/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)

check: run
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/membus_tb.sv */
// Testbench for the bus fabric driving random memory and I/O cycles from an LFSR
`timescale 1ns/10ps
`default_nettype none

`include "membus_settings.svh"

module membus_tb;

  import membus_pkg::*;

  localparam int NUM_TXN        = 600;
  localparam int RESET_CYCLES   = 16;
  localparam int TIMEOUT_CYCLES = NUM_TXN * 4 + RESET_CYCLES;

  logic        clk = 1'b0;
  logic        arst_n_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  logic        wb_tga_i;
  addr_t       wb_adr_i;
  word_t       wb_dat_i;
  sel_t        wb_sel_i;
  logic        wb_ack_o;
  word_t       wb_dat_o;
  word_t       led_o;
  int          xfer_cnt;
  int          mismatch_cnt;
  int          protocol_cnt;
  int          cycle_cnt = 0;
  logic [15:0] lfsr_q = 16'd37;
  logic [31:0] r;
  logic        tga;
  logic        we;
  addr_t       adr;
  sel_t        sel;
  word_t       dat;

  membus_top dut0 (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_sel_i (wb_sel_i),
    .wb_we_i  (wb_we_i),
    .wb_tga_i (wb_tga_i),
    .wb_stb_i (wb_stb_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_ack_o (wb_ack_o),
    .wb_dat_o (wb_dat_o),
    .led_o    (led_o)
  );

  membus_checker u_checker (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .wb_cyc_i       (wb_cyc_i),
    .wb_stb_i       (wb_stb_i),
    .wb_we_i        (wb_we_i),
    .wb_tga_i       (wb_tga_i),
    .wb_adr_i       (wb_adr_i),
    .wb_wdat_i      (wb_dat_i),
    .wb_sel_i       (wb_sel_i),
    .wb_ack_i       (wb_ack_o),
    .wb_rdat_i      (wb_dat_o),
    .led_i          (led_o),
    .xfer_cnt_o     (xfer_cnt),
    .mismatch_cnt_o (mismatch_cnt),
    .protocol_cnt_o (protocol_cnt)
  );

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  // One classic cycle held until ack and followed by an idle cycle
  task automatic bus_cycle(input logic c_tga, input logic c_we, input addr_t c_adr,
                           input sel_t c_sel, input word_t c_dat);
    wb_tga_i = c_tga;
    wb_we_i  = c_we;
    wb_adr_i = c_adr;
    wb_sel_i = c_sel;
    wb_dat_i = c_dat;
    wb_stb_i = 1'b1;
    wb_cyc_i = 1'b1;
    @(negedge clk);
    while (!wb_ack_o) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
    @(posedge clk);
    #1;
  endtask

  initial begin
    forever #2 clk = ~clk;
  end

  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, the bus handshake did not complete", cycle_cnt);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    arst_n_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_tga_i = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    arst_n_i = 1'b1;
    @(posedge clk);
    #1;
    for (int t = 0; t < NUM_TXN; t++) begin
      // One in four cycles goes to I/O space
      take_bits(2, r);
      tga = (r[1:0] == 2'b11);
      take_bits(1, r);
      we = r[0];
      take_bits(19, r);
      adr = r[18:0];
      take_bits(1, r);
      // Half the I/O hits the LED page and half the memory uses few indexes
      if (tga && r[0]) begin
        adr[15:8] = `MEMBUS_LED_PAGE;
      end else if (!tga && r[0]) begin
        adr[7:3] = '0;
      end
      take_bits(2, r);
      sel = r[1:0];
      take_bits(16, r);
      dat = r[15:0];
      bus_cycle(tga, we, adr, sel, dat);
    end
    repeat (2) @(posedge clk);
    if (xfer_cnt != NUM_TXN) begin
      $display("Checker saw %0d accepted cycles, driver issued %0d", xfer_cnt, NUM_TXN);
    end
    $display("Transfers %0d, mismatches %0d, protocol errors %0d",
             xfer_cnt, mismatch_cnt, protocol_cnt);
    if (mismatch_cnt == 0 && protocol_cnt == 0 && xfer_cnt == NUM_TXN) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/membus_checker.sv */
// Bus checker that models the banks and LED register and compares every accepted cycle
`timescale 1ns/10ps
`default_nettype none

`include "membus_settings.svh"

module membus_checker (
  input  wire                    clk,
  input  wire                    arst_n_i,
  input  wire                    wb_cyc_i,
  input  wire                    wb_stb_i,
  input  wire                    wb_we_i,
  input  wire                    wb_tga_i,
  input  wire membus_pkg::addr_t wb_adr_i,
  input  wire membus_pkg::word_t wb_wdat_i,
  input  wire membus_pkg::sel_t  wb_sel_i,
  input  wire                    wb_ack_i,
  input  wire membus_pkg::word_t wb_rdat_i,
  input  wire membus_pkg::word_t led_i,
  output int                     xfer_cnt_o,
  output int                     mismatch_cnt_o,
  output int                     protocol_cnt_o
);

  import membus_pkg::*;

  localparam int LANES = `MEMBUS_DATA_W / 8;
  localparam int DEPTH = 2 ** `MEMBUS_BANK_AW;

  word_t      mem_model [`MEMBUS_NUM_BANKS][DEPTH];
  sel_t       lane_ok   [`MEMBUS_NUM_BANKS][DEPTH];
  word_t      led_model;
  word_t      exp_word;
  bank_idx_t  bank;
  ram_idx_t   idx;
  logic       ack_due;
  int         wait_cnt = 0;
  int         xfer_cnt = 0;
  int         mismatch_cnt = 0;
  int         protocol_cnt = 0;

  assign xfer_cnt_o     = xfer_cnt;
  assign mismatch_cnt_o = mismatch_cnt;
  assign protocol_cnt_o = protocol_cnt;

  // Model update and data compare for one acknowledged cycle
  task automatic accept_cycle();
    bank = wb_adr_i[`MEMBUS_ADDR_W-1 -: 2];
    idx  = wb_adr_i[`MEMBUS_BANK_AW-1:0];
    xfer_cnt++;
    if (wb_tga_i) begin
      if (wb_we_i) begin
        if (wb_adr_i[15:8] == `MEMBUS_LED_PAGE) begin
          led_model = wb_wdat_i;
        end
      end else begin
        exp_word = (wb_adr_i[15:8] == `MEMBUS_LED_PAGE) ? led_model : '0;
        if (wb_rdat_i !== exp_word) begin
          $display("MISMATCH at %0t: I/O read page %h returned %h, expected %h",
                   $time, wb_adr_i[15:8], wb_rdat_i, exp_word);
          mismatch_cnt++;
        end
      end
    end else begin
      for (int b = 0; b < LANES; b++) begin
        if (wb_we_i && wb_sel_i[b]) begin
          mem_model[bank][idx][b*8 +: 8] = wb_wdat_i[b*8 +: 8];
          lane_ok[bank][idx][b] = 1'b1;
        end else if (!wb_we_i && lane_ok[bank][idx][b] &&
                     wb_rdat_i[b*8 +: 8] !== mem_model[bank][idx][b*8 +: 8]) begin
          $display("MISMATCH at %0t: bank %0d index %0d lane %0d read %h, expected %h",
                   $time, bank, idx, b, wb_rdat_i[b*8 +: 8],
                   mem_model[bank][idx][b*8 +: 8]);
          mismatch_cnt++;
        end
      end
    end
  endtask

  // Sampled mid-cycle, away from the edges where inputs and registers move
  always @(negedge clk) begin
    if (!arst_n_i) begin
      if (wb_ack_i !== 1'b0 || led_i !== '0) begin
        $display("Reset error at %0t: ack or LED output is not cleared", $time);
        protocol_cnt++;
      end
      led_model = '0;
      wait_cnt  = 0;
      for (int b = 0; b < `MEMBUS_NUM_BANKS; b++) begin
        for (int i = 0; i < DEPTH; i++) begin
          lane_ok[b][i] = '0;
        end
      end
    end else begin
      if (led_i !== led_model) begin
        $display("MISMATCH at %0t: led_o is %h, expected %h", $time, led_i, led_model);
        mismatch_cnt++;
      end
      if (wb_stb_i && wb_cyc_i) begin
        // I/O acks at once, memory after exactly one wait state
        ack_due = wb_tga_i || (wait_cnt == 1);
        if (wb_ack_i !== ack_due) begin
          $display("Protocol error at %0t: %s cycle ack is %b after %0d wait cycles",
                   $time, wb_tga_i ? "I/O" : "memory", wb_ack_i, wait_cnt);
          protocol_cnt++;
        end
        if (wb_ack_i === 1'b1) begin
          accept_cycle();
          wait_cnt = 0;
        end else begin
          wait_cnt++;
        end
      end else begin
        if (wb_ack_i !== 1'b0) begin
          $display("Protocol error at %0t: ack is high without a strobe", $time);
          protocol_cnt++;
        end
        wait_cnt = 0;
      end
    end
  end

endmodule

`default_nettype wire

/* source/membus_top.sv */
// Memory and I/O bus fabric top with decoder, RAM banks, LED port and reply merger
`timescale 1ns/10ps
`default_nettype none

`include "membus_settings.svh"

module membus_top (
  input  wire                    clk,
  input  wire                    arst_n_i,
  input  wire membus_pkg::addr_t wb_adr_i,
  input  wire membus_pkg::word_t wb_dat_i,
  input  wire membus_pkg::sel_t  wb_sel_i,
  input  wire                    wb_we_i,
  input  wire                    wb_tga_i,
  input  wire                    wb_stb_i,
  input  wire                    wb_cyc_i,
  output logic                   wb_ack_o,
  output membus_pkg::word_t      wb_dat_o,
  output membus_pkg::word_t      led_o
);

  import membus_pkg::*;

  logic [`MEMBUS_NUM_BANKS-1:0]  bank_stb;
  logic [`MEMBUS_NUM_BANKS-1:0]  bank_ack;
  word_t [`MEMBUS_NUM_BANKS-1:0] bank_rdata;
  ram_idx_t                      ram_idx;
  logic                          io_stb;
  logic                          io_hit;
  word_t                         led_value;

  arena_decoder u_decoder (
    .wb_adr_i   (wb_adr_i),
    .wb_tga_i   (wb_tga_i),
    .wb_stb_i   (wb_stb_i),
    .wb_cyc_i   (wb_cyc_i),
    .bank_stb_o (bank_stb),
    .io_stb_o   (io_stb),
    .ram_idx_o  (ram_idx)
  );

  // Index, data, selects and we fan out to every bank
  for (genvar i = 0; i < `MEMBUS_NUM_BANKS; i++) begin : g_bank
    mem_bank u_bank (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .stb_i    (bank_stb[i]),
      .we_i     (wb_we_i),
      .sel_i    (wb_sel_i),
      .idx_i    (ram_idx),
      .wdata_i  (wb_dat_i),
      .ack_o    (bank_ack[i]),
      .rdata_o  (bank_rdata[i])
    );
  end

  led_port u_led (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .io_stb_i (io_stb),
    .we_i     (wb_we_i),
    .page_i   (wb_adr_i[15:8]),
    .wdata_i  (wb_dat_i),
    .led_o    (led_value),
    .hit_o    (io_hit)
  );

  bus_reply u_reply (
    .bank_ack_i   (bank_ack),
    .bank_rdata_i (bank_rdata),
    .io_stb_i     (io_stb),
    .io_hit_i     (io_hit),
    .led_i        (led_value),
    .wb_ack_o     (wb_ack_o),
    .wb_dat_o     (wb_dat_o)
  );

  assign led_o = led_value;

endmodule

`default_nettype wire

/* source/bus_reply.sv */
// Reply merger that folds bank and I/O acks and read data back to the master
`timescale 1ns/10ps
`default_nettype none

`include "membus_settings.svh"

module bus_reply (
  input  wire [`MEMBUS_NUM_BANKS-1:0]                    bank_ack_i,
  input  wire membus_pkg::word_t [`MEMBUS_NUM_BANKS-1:0] bank_rdata_i,
  input  wire                                            io_stb_i,
  input  wire                                            io_hit_i,
  input  wire membus_pkg::word_t                         led_i,
  output logic                                           wb_ack_o,
  output membus_pkg::word_t                              wb_dat_o
);

  import membus_pkg::*;

  word_t mem_dat;

  // I/O acks in the same cycle, banks after their wait state
  assign wb_ack_o = (|bank_ack_i) | io_stb_i;

  // At most one bank acks at a time on a classic bus
  always_comb begin
    mem_dat = '0;
    for (int i = 0; i < `MEMBUS_NUM_BANKS; i++) begin
      if (bank_ack_i[i]) begin
        mem_dat = bank_rdata_i[i];
      end
    end
  end

  // Unmapped port pages read as zero
  always_comb begin
    if (io_stb_i) begin
      wb_dat_o = io_hit_i ? led_i : '0;
    end else begin
      wb_dat_o = mem_dat;
    end
  end

endmodule

`default_nettype wire

/* source/led_port.sv */
// LED output register on I/O page 0xF1, loaded by port writes
`timescale 1ns/10ps
`default_nettype none

`include "membus_settings.svh"

module led_port (
  input  wire                    clk,
  input  wire                    arst_n_i,
  input  wire                    io_stb_i,
  input  wire                    we_i,
  input  wire [7:0]              page_i,
  input  wire membus_pkg::word_t wdata_i,
  output membus_pkg::word_t      led_o,
  output logic                   hit_o
);

  import membus_pkg::*;

  word_t led_q;

  // Page match, also used by the reply mux
  assign hit_o = (page_i == `MEMBUS_LED_PAGE);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      led_q <= '0;
    end else if (io_stb_i && we_i && hit_o) begin
      led_q <= wdata_i;
    end
  end

  assign led_o = led_q;

endmodule

`default_nettype wire

/* source/mem_bank.sv */
// On-chip byte-lane RAM bank that acknowledges after one wait state
`timescale 1ns/10ps
`default_nettype none

`include "membus_settings.svh"

module mem_bank (
  input  wire                      clk,
  input  wire                      arst_n_i,
  input  wire                      stb_i,
  input  wire                      we_i,
  input  wire membus_pkg::sel_t    sel_i,
  input  wire membus_pkg::ram_idx_t idx_i,
  input  wire membus_pkg::word_t   wdata_i,
  output logic                     ack_o,
  output membus_pkg::word_t        rdata_o
);

  import membus_pkg::*;

  localparam int LANES = `MEMBUS_DATA_W / 8;
  localparam int DEPTH = 2 ** `MEMBUS_BANK_AW;

  word_t       mem [DEPTH];
  word_t       rdata_q;
  bank_state_e state_q;
  bank_state_e state_d;

  // Handshake FSM
  always_comb begin
    state_d = state_q;
    case (state_q)
      BANK_IDLE: begin
        if (stb_i) begin
          state_d = BANK_ACK;
        end
      end
      // Always drops back, a held strobe gets no second ack
      BANK_ACK: state_d = BANK_IDLE;
      default:  state_d = BANK_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= BANK_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Read word captured on the wait state, write lands as the ack cycle closes
  always_ff @(posedge clk) begin
    if (state_q == BANK_IDLE && stb_i) begin
      rdata_q <= mem[idx_i];
    end
    if (state_q == BANK_ACK && stb_i && we_i) begin
      for (int b = 0; b < LANES; b++) begin
        if (sel_i[b]) begin
          mem[idx_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  assign ack_o   = (state_q == BANK_ACK);
  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* source/arena_decoder.sv */
// Address decoder that steers a bus cycle to one memory bank or to I/O
`timescale 1ns/10ps
`default_nettype none

`include "membus_settings.svh"

module arena_decoder (
  input  wire membus_pkg::addr_t         wb_adr_i,
  input  wire                            wb_tga_i,
  input  wire                            wb_stb_i,
  input  wire                            wb_cyc_i,
  output logic [`MEMBUS_NUM_BANKS-1:0]   bank_stb_o,
  output logic                           io_stb_o,
  output membus_pkg::ram_idx_t           ram_idx_o
);

  import membus_pkg::*;

  logic      cycle_live;
  logic      mem_live;
  bank_idx_t bank_sel;

  // Only a strobe inside an open cycle counts
  assign cycle_live = wb_stb_i & wb_cyc_i;

  // Tag high means port space, low means memory
  assign io_stb_o = cycle_live & wb_tga_i;
  assign mem_live = cycle_live & ~wb_tga_i;

  // Bank field is the top of the word address
  assign bank_sel = wb_adr_i[`MEMBUS_ADDR_W-1 -: $bits(bank_idx_t)];

  // Low bits index the word, bits in between alias
  assign ram_idx_o = wb_adr_i[`MEMBUS_BANK_AW-1:0];

  // One-hot bank strobe on memory cycles
  always_comb begin
    for (int i = 0; i < `MEMBUS_NUM_BANKS; i++) begin
      bank_stb_o[i] = mem_live && (bank_sel == bank_idx_t'(i));
    end
  end

endmodule

`default_nettype wire

/* source/membus_pkg.sv */
// Memory bus fabric package with the bus vector types and the bank FSM states
`default_nettype none

`include "membus_settings.svh"

package membus_pkg;

  // Bus vectors
  typedef logic [`MEMBUS_ADDR_W-1:0] addr_t;
  typedef logic [`MEMBUS_DATA_W-1:0] word_t;
  typedef logic [`MEMBUS_DATA_W/8-1:0] sel_t;

  // Bank number and word index inside a bank
  typedef logic [$clog2(`MEMBUS_NUM_BANKS)-1:0] bank_idx_t;
  typedef logic [`MEMBUS_BANK_AW-1:0] ram_idx_t;

  // Bank handshake, one wait state then ack
  typedef enum logic {
    BANK_IDLE = 1'b0,
    BANK_ACK  = 1'b1
  } bank_state_e;

endpackage

`default_nettype wire

/* source/membus_settings.svh */
// Memory bus fabric settings for widths, bank geometry and the LED port page
`ifndef MEMBUS_SETTINGS_SVH
`define MEMBUS_SETTINGS_SVH

// Word address from the master, byte address bit 0 dropped
`define MEMBUS_ADDR_W 19

// Data word, two byte lanes
`define MEMBUS_DATA_W 16

// Banks picked by the top address bits
`define MEMBUS_NUM_BANKS 4

// log2 of words held by each bank
`define MEMBUS_BANK_AW 8

// I/O page of the LED register, matched against address bits 15..8
`define MEMBUS_LED_PAGE 8'hF1

`endif
